// File: design/spiDefines.svh
/*
 * Address map, bus widths and reset values
 * for the SPI master subsystem
 */

`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

`default_nettype none

// --------------------
// Bus widths
// --------------------
// APB address width
`define SPI_ADDR_W 16
// APB data width
`define SPI_DATA_W 32

// --------------------
// SPI block
// --------------------
// Half-period divider width
`define SPI_DIV_W 16
// Address bits 15..8 that select the SPI block
`define SPI_BLOCK_SEL 8'h03
// Divider after reset, slowest SCLK
`define SPI_DIV_RST {`SPI_DIV_W{1'b1}}

`default_nettype wire

`endif

// File: design/spiPkg.sv
/*
 * Shared types of the SPI subsystem
 * Arbiter phase, shifter phase, register offsets
 */

`default_nettype none

package spiPkg;

	// --------------------
	// APB arbiter phase
	// --------------------
	typedef enum logic [1:0] {
		ARB_IDLE   = 2'd0,
		ARB_SETUP  = 2'd1,
		ARB_ACCESS = 2'd2
	} arbState;

	// --------------------
	// Shift engine phase
	// --------------------
	// Low and high halves of each SCLK period
	typedef enum logic [1:0] {
		SH_IDLE = 2'd0,
		SH_LOW  = 2'd1,
		SH_HIGH = 2'd2,
		SH_DONE = 2'd3
	} shiftState;

	// --------------------
	// Register offsets
	// --------------------
	// Low address byte inside the SPI block
	typedef enum logic [7:0] {
		CSR_CTRL   = 8'h00,
		CSR_DIV    = 8'h04,
		CSR_TXDATA = 8'h08,
		CSR_CS     = 8'h0C,
		CSR_RXDATA = 8'h80
	} csrOffset;

endpackage

`default_nettype wire

// File: design/apbArbiter.sv
/*
 * Round-robin APB arbiter
 * Two requester ports merged onto one shared APB bus
 * Response routed back to the granted host only
 */

`timescale 1ns/1ps
`include "spiDefines.svh"
`default_nettype none

module apbArbiter
(
	input  wire                    iSysClk,
	input  wire                    rst,
	// Host A
	input  wire                    aPsel,
	input  wire                    aPenable,
	input  wire                    aPwrite,
	input  wire [`SPI_ADDR_W-1:0]  aPaddr,
	input  wire [`SPI_DATA_W-1:0]  aPwdata,
	output logic [`SPI_DATA_W-1:0] aPrdata,
	output logic                   aPready,
	output logic                   aPslverr,
	// Host B
	input  wire                    bPsel,
	input  wire                    bPenable,
	input  wire                    bPwrite,
	input  wire [`SPI_ADDR_W-1:0]  bPaddr,
	input  wire [`SPI_DATA_W-1:0]  bPwdata,
	output logic [`SPI_DATA_W-1:0] bPrdata,
	output logic                   bPready,
	output logic                   bPslverr,
	// Shared bus
	output logic                   busPsel,
	output logic                   busPenable,
	output logic                   busPwrite,
	output logic [`SPI_ADDR_W-1:0] busPaddr,
	output logic [`SPI_DATA_W-1:0] busPwdata,
	input  wire [`SPI_DATA_W-1:0]  busPrdata,
	input  wire                    busPready,
	input  wire                    busPslverr
);
	import spiPkg::*;

	arbState state;
	// Set while host B owns the current transfer
	logic    grantB;
	// Host served by the last finished transfer
	logic    lastB;
	logic    doneA;
	logic    doneB;

	// --------------------
	// Grant FSM
	// --------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			state  <= ARB_IDLE;
			grantB <= 1'b0;
			// A wins the first tie
			lastB  <= 1'b1;
		end
		else
		begin
			case (state)
				ARB_IDLE:
				begin
					// Tie goes to the host not served last
					if (aPsel && bPsel)
					begin
						grantB <= ~lastB;
						state  <= ARB_SETUP;
					end
					else if (aPsel || bPsel)
					begin
						grantB <= bPsel;
						state  <= ARB_SETUP;
					end
				end
				ARB_SETUP:
				begin
					state <= ARB_ACCESS;
				end
				ARB_ACCESS:
				begin
					// Stay here until the slave answers
					if (busPready)
					begin
						lastB <= grantB;
						state <= ARB_IDLE;
					end
				end
				default:
				begin
					state <= ARB_IDLE;
				end
			endcase
		end
	end

	// --------------------
	// Request mux
	// --------------------
	assign busPsel    = (state == ARB_SETUP) || (state == ARB_ACCESS);
	assign busPenable = (state == ARB_ACCESS);
	assign busPwrite  = grantB ? bPwrite : aPwrite;
	assign busPaddr   = grantB ? bPaddr  : aPaddr;
	assign busPwdata  = grantB ? bPwdata : aPwdata;

	// --------------------
	// Response routing
	// --------------------
	// Loser keeps Pready low and waits
	assign doneA = busPenable && busPready && !grantB && aPenable;
	assign doneB = busPenable && busPready && grantB && bPenable;

	assign aPready  = doneA;
	assign aPslverr = doneA && busPslverr;
	assign aPrdata  = doneA ? busPrdata : '0;

	assign bPready  = doneB;
	assign bPslverr = doneB && busPslverr;
	assign bPrdata  = doneB ? busPrdata : '0;

endmodule

`default_nettype wire

// File: design/spiCsr.sv
/*
 * SPI control/status registers on APB
 * Block decode, register file, read mux
 * Start pulse and sticky done flag
 */

`timescale 1ns/1ps
`include "spiDefines.svh"
`default_nettype none

module spiCsr
(
	input  wire                    iSysClk,
	input  wire                    rst,
	// Shared APB bus
	input  wire                    busPsel,
	input  wire                    busPenable,
	input  wire                    busPwrite,
	input  wire [`SPI_ADDR_W-1:0]  busPaddr,
	input  wire [`SPI_DATA_W-1:0]  busPwdata,
	output logic [`SPI_DATA_W-1:0] busPrdata,
	output logic                   busPready,
	output logic                   busPslverr,
	// To the shift engine
	output logic                   startPulse,
	output logic [`SPI_DIV_W-1:0]  divValue,
	output logic [7:0]             txByte,
	output logic                   csN,
	// From the shift engine
	input  wire                    busy,
	input  wire                    done,
	input  wire [7:0]              rxByte
);
	import spiPkg::*;

	csrOffset              offset;
	logic                  access;
	logic                  blockHit;
	logic                  wrEn;
	logic [`SPI_DATA_W-1:0] rdMux;

	// Register file
	logic [`SPI_DIV_W-1:0] divReg;
	logic [7:0]            txReg;
	logic                  csReg;
	logic [7:0]            rxReg;
	logic                  doneReg;
	logic                  startReg;

	// --------------------
	// Decode
	// --------------------
	assign access   = busPsel && busPenable;
	assign blockHit = (busPaddr[`SPI_ADDR_W-1:8] == `SPI_BLOCK_SEL);
	assign offset   = csrOffset'(busPaddr[7:0]);
	assign wrEn     = access && busPwrite && blockHit;

	// Zero-wait slave
	assign busPready  = access;
	// Outside the block
	assign busPslverr = access && !blockHit;

	// --------------------
	// Register write
	// --------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			divReg   <= `SPI_DIV_RST;
			txReg    <= 8'h00;
			csReg    <= 1'b1;
			doneReg  <= 1'b0;
			startReg <= 1'b0;
		end
		else
		begin
			// One cycle only unless set again below
			startReg <= 1'b0;
			if (wrEn)
			begin
				case (offset)
					CSR_CTRL:
					begin
						// Start ignored while a frame runs
						startReg <= busPwdata[0] && !busy;
						doneReg  <= 1'b0;
					end
					CSR_DIV:    divReg <= busPwdata[`SPI_DIV_W-1:0];
					CSR_TXDATA: txReg  <= busPwdata[7:0];
					CSR_CS:     csReg  <= busPwdata[0];
					// RXDATA is read-only and holes ignore writes
					default:    ;
				endcase
			end
			// Done pulse wins over a clearing write
			if (done)
				doneReg <= 1'b1;
		end
	end

	// Received byte latched at the end of a frame
	always_ff @(posedge iSysClk)
	begin
		if (done)
			rxReg <= rxByte;
	end

	// --------------------
	// Read mux
	// --------------------
	always_comb
	begin
		case (offset)
			CSR_CTRL:   rdMux = {{(`SPI_DATA_W-2){1'b0}}, doneReg, busy};
			CSR_DIV:    rdMux = {{(`SPI_DATA_W-`SPI_DIV_W){1'b0}}, divReg};
			CSR_TXDATA: rdMux = {{(`SPI_DATA_W-8){1'b0}}, txReg};
			CSR_CS:     rdMux = {{(`SPI_DATA_W-1){1'b0}}, csReg};
			CSR_RXDATA: rdMux = {{(`SPI_DATA_W-8){1'b0}}, rxReg};
			default:    rdMux = '0;
		endcase
	end

	assign busPrdata = (access && blockHit && !busPwrite) ? rdMux : '0;

	// --------------------
	// Outputs
	// --------------------
	assign startPulse = startReg;
	assign divValue   = divReg;
	assign txByte     = txReg;
	assign csN        = csReg;

endmodule

`default_nettype wire

// File: design/spiShifter.sv
/*
 * SPI mode 0 shift engine, MSB first, 8-bit frames
 * SCLK half-period divider and bit counter
 * MOSI shift-out and MISO capture
 */

`timescale 1ns/1ps
`include "spiDefines.svh"
`default_nettype none

module spiShifter
(
	input  wire                   iSysClk,
	input  wire                   rst,
	// Control from the register block
	input  wire                   startPulse,
	input  wire [`SPI_DIV_W-1:0]  divValue,
	input  wire [7:0]             txByte,
	output logic                  busy,
	output logic                  done,
	output logic [7:0]            rxByte,
	// SPI pins
	output logic                  sclk,
	output logic                  mosi,
	input  wire                   miso
);
	import spiPkg::*;

	shiftState            state;
	// Counts down system clocks of one SCLK half
	logic [`SPI_DIV_W-1:0] halfCnt;
	logic [2:0]           bitCnt;
	// Bit 7 is the bit on MOSI
	logic [7:0]           txShift;
	logic [7:0]           rxShift;
	logic [7:0]           rxReg;
	logic                 sclkReg;
	logic                 busyReg;
	logic                 doneReg;
	logic                 halfEnd;
	logic                 sampleEn;

	assign halfEnd = (halfCnt == '0);
	// Rising SCLK edge
	assign sampleEn = (state == SH_LOW) && halfEnd;

	// --------------------
	// Frame FSM
	// --------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			state   <= SH_IDLE;
			halfCnt <= '0;
			bitCnt  <= 3'd0;
			txShift <= 8'h00;
			sclkReg <= 1'b0;
			busyReg <= 1'b0;
			doneReg <= 1'b0;
		end
		else
		begin
			doneReg <= 1'b0;
			case (state)
				SH_IDLE:
				begin
					if (startPulse)
					begin
						// First bit on MOSI before the first rising edge
						txShift <= txByte;
						halfCnt <= divValue;
						bitCnt  <= 3'd0;
						busyReg <= 1'b1;
						state   <= SH_LOW;
					end
				end
				SH_LOW:
				begin
					if (halfEnd)
					begin
						sclkReg <= 1'b1;
						halfCnt <= divValue;
						state   <= SH_HIGH;
					end
					else
						halfCnt <= halfCnt - 1'b1;
				end
				SH_HIGH:
				begin
					if (halfEnd)
					begin
						sclkReg <= 1'b0;
						halfCnt <= divValue;
						if (bitCnt == 3'd7)
							state <= SH_DONE;
						else
						begin
							// Next bit out on the falling edge
							txShift <= {txShift[6:0], 1'b0};
							bitCnt  <= bitCnt + 1'b1;
							state   <= SH_LOW;
						end
					end
					else
						halfCnt <= halfCnt - 1'b1;
				end
				SH_DONE:
				begin
					txShift <= 8'h00;
					busyReg <= 1'b0;
					doneReg <= 1'b1;
					state   <= SH_IDLE;
				end
				default:
				begin
					state <= SH_IDLE;
				end
			endcase
		end
	end

	// --------------------
	// MISO capture
	// --------------------
	always_ff @(posedge iSysClk)
	begin
		if (sampleEn)
			rxShift <= {rxShift[6:0], miso};
		// Valid together with done
		if (state == SH_DONE)
			rxReg <= rxShift;
	end

	// --------------------
	// Outputs
	// --------------------
	assign sclk   = sclkReg;
	assign mosi   = txShift[7];
	assign busy   = busyReg;
	assign done   = doneReg;
	assign rxByte = rxReg;

endmodule

`default_nettype wire

// File: design/spiSubsys.sv
/*
 * SPI master subsystem top
 * Arbiter, register block and shift engine
 */

`timescale 1ns/1ps
`include "spiDefines.svh"
`default_nettype none

module spiSubsys
(
	input  wire                    iSysClk,
	input  wire                    rst,
	// Host A
	input  wire                    aPsel,
	input  wire                    aPenable,
	input  wire                    aPwrite,
	input  wire [`SPI_ADDR_W-1:0]  aPaddr,
	input  wire [`SPI_DATA_W-1:0]  aPwdata,
	output logic [`SPI_DATA_W-1:0] aPrdata,
	output logic                   aPready,
	output logic                   aPslverr,
	// Host B
	input  wire                    bPsel,
	input  wire                    bPenable,
	input  wire                    bPwrite,
	input  wire [`SPI_ADDR_W-1:0]  bPaddr,
	input  wire [`SPI_DATA_W-1:0]  bPwdata,
	output logic [`SPI_DATA_W-1:0] bPrdata,
	output logic                   bPready,
	output logic                   bPslverr,
	// SPI pins
	output logic                   sclk,
	output logic                   mosi,
	input  wire                    miso,
	output logic                   csN
);

	// --------------------
	// Shared APB bus
	// --------------------
	logic                   busPsel;
	logic                   busPenable;
	logic                   busPwrite;
	logic [`SPI_ADDR_W-1:0] busPaddr;
	logic [`SPI_DATA_W-1:0] busPwdata;
	logic [`SPI_DATA_W-1:0] busPrdata;
	logic                   busPready;
	logic                   busPslverr;

	// Register block to engine
	logic                   startPulse;
	logic [`SPI_DIV_W-1:0]  divValue;
	logic [7:0]             txByte;
	logic                   busy;
	logic                   done;
	logic [7:0]             rxByte;

	apbArbiter uArbiter
	(
		.iSysClk    (iSysClk),
		.rst        (rst),
		.aPsel      (aPsel),
		.aPenable   (aPenable),
		.aPwrite    (aPwrite),
		.aPaddr     (aPaddr),
		.aPwdata    (aPwdata),
		.aPrdata    (aPrdata),
		.aPready    (aPready),
		.aPslverr   (aPslverr),
		.bPsel      (bPsel),
		.bPenable   (bPenable),
		.bPwrite    (bPwrite),
		.bPaddr     (bPaddr),
		.bPwdata    (bPwdata),
		.bPrdata    (bPrdata),
		.bPready    (bPready),
		.bPslverr   (bPslverr),
		.busPsel    (busPsel),
		.busPenable (busPenable),
		.busPwrite  (busPwrite),
		.busPaddr   (busPaddr),
		.busPwdata  (busPwdata),
		.busPrdata  (busPrdata),
		.busPready  (busPready),
		.busPslverr (busPslverr)
	);

	spiCsr uCsr
	(
		.iSysClk    (iSysClk),
		.rst        (rst),
		.busPsel    (busPsel),
		.busPenable (busPenable),
		.busPwrite  (busPwrite),
		.busPaddr   (busPaddr),
		.busPwdata  (busPwdata),
		.busPrdata  (busPrdata),
		.busPready  (busPready),
		.busPslverr (busPslverr),
		.startPulse (startPulse),
		.divValue   (divValue),
		.txByte     (txByte),
		.csN        (csN),
		.busy       (busy),
		.done       (done),
		.rxByte     (rxByte)
	);

	spiShifter uShifter
	(
		.iSysClk    (iSysClk),
		.rst        (rst),
		.startPulse (startPulse),
		.divValue   (divValue),
		.txByte     (txByte),
		.busy       (busy),
		.done       (done),
		.rxByte     (rxByte),
		.sclk       (sclk),
		.mosi       (mosi),
		.miso       (miso)
	);

endmodule

`default_nettype wire

// File: verification/tbSpiSubsys.sv
/*
 * Directed testbench for the SPI master subsystem
 * Clock, reset, DUT, SPI slave model, SCLK phase monitor
 * APB host tasks, compare tasks, directed tests, summary
 */

`timescale 1ns/1ps
`include "spiDefines.svh"
`default_nettype none

module tbSpiSubsys;
	import spiPkg::*;

	// Pready wait limit in cycles
	localparam int BUS_TIMEOUT = 20;
	// CTRL polls before a frame counts as stuck
	localparam int POLL_LIMIT  = 100;

	logic                   iSysClk = 1'b0;
	logic                   rst;
	logic                   aPsel;
	logic                   aPenable;
	logic                   aPwrite;
	logic [`SPI_ADDR_W-1:0] aPaddr;
	logic [`SPI_DATA_W-1:0] aPwdata;
	logic [`SPI_DATA_W-1:0] aPrdata;
	logic                   aPready;
	logic                   aPslverr;
	logic                   bPsel;
	logic                   bPenable;
	logic                   bPwrite;
	logic [`SPI_ADDR_W-1:0] bPaddr;
	logic [`SPI_DATA_W-1:0] bPwdata;
	logic [`SPI_DATA_W-1:0] bPrdata;
	logic                   bPready;
	logic                   bPslverr;
	logic                   sclk;
	logic                   mosi;
	logic                   miso;
	logic                   csN;

	// Bookkeeping
	integer seed = 5280;
	string  curTest;
	int     testErrors;
	int     totalErrors = 0;
	int     passCount = 0;
	int     failCount = 0;
	event   timeoutEv;
	string  timeoutWhat;

	// 20 ns period
	always #10 iSysClk = ~iSysClk;

	spiSubsys DUT
	(
		.iSysClk (iSysClk),
		.rst     (rst),
		.aPsel   (aPsel),
		.aPenable(aPenable),
		.aPwrite (aPwrite),
		.aPaddr  (aPaddr),
		.aPwdata (aPwdata),
		.aPrdata (aPrdata),
		.aPready (aPready),
		.aPslverr(aPslverr),
		.bPsel   (bPsel),
		.bPenable(bPenable),
		.bPwrite (bPwrite),
		.bPaddr  (bPaddr),
		.bPwdata (bPwdata),
		.bPrdata (bPrdata),
		.bPready (bPready),
		.bPslverr(bPslverr),
		.sclk    (sclk),
		.mosi    (mosi),
		.miso    (miso),
		.csN     (csN)
	);

	// --------------------
	// SPI slave model
	// --------------------
	logic [7:0] replyByte;
	logic [7:0] slaveTx;
	logic [7:0] slaveRx;

	// First reply bit as soon as the slave is selected
	always @(negedge csN)
	begin
		slaveTx = replyByte;
		miso <= replyByte[7];
	end

	// Mode 0, next bit after each falling edge
	always @(negedge sclk)
	begin
		if (!csN)
		begin
			slaveTx = {slaveTx[6:0], 1'b0};
			miso <= slaveTx[7];
		end
	end

	always @(posedge sclk)
	begin
		if (!csN)
			slaveRx <= {slaveRx[6:0], mosi};
	end

	// --------------------
	// SCLK phase monitor
	// --------------------
	int   cycCnt = 0;
	int   lastEdge = 0;
	int   riseCnt = 0;
	int   phaseLen[$];
	logic prevSclk = 1'b0;
	logic havePrev = 1'b0;
	logic measureOn = 1'b0;

	// Counted in system clocks, sampled away from the active edge
	always @(negedge iSysClk)
	begin
		cycCnt++;
		if (sclk !== prevSclk)
		begin
			// Only phases bounded by two edges inside the window
			if (measureOn && havePrev)
				phaseLen.push_back(cycCnt - lastEdge);
			if (measureOn && sclk === 1'b1)
				riseCnt++;
			lastEdge = cycCnt;
			havePrev = measureOn;
		end
		prevSclk = sclk;
	end

	// Stuck wait ends the run here
	initial
	begin
		arbState st;
		@(timeoutEv);
		st = DUT.uArbiter.state;
		$display("Timeout while waiting for %s in %s, arbiter in %s",
			timeoutWhat, curTest, st.name());
		$display("test failed");
		$finish;
	end

	task automatic reportTimeout(input string what);
		timeoutWhat = what;
		-> timeoutEv;
		// Parked until the run ends
		forever @(posedge iSysClk);
	endtask

	// --------------------
	// Compare tasks
	// --------------------
	task automatic checkData(input string what, input logic [`SPI_DATA_W-1:0] exp,
		input logic [`SPI_DATA_W-1:0] act);
		if (act !== exp)
		begin
			$display("ERROR %s %s: expected 0x%08h, actual 0x%08h", curTest, what, exp, act);
			testErrors++;
		end
	endtask

	task automatic checkByte(input string what, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
		begin
			$display("ERROR %s %s: expected 0x%02h, actual 0x%02h", curTest, what, exp, act);
			testErrors++;
		end
	endtask

	task automatic checkFlag(input string what, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("ERROR %s %s: expected %b, actual %b", curTest, what, exp, act);
			testErrors++;
		end
	endtask

	// --------------------
	// APB host tasks
	// --------------------
	function automatic logic [`SPI_ADDR_W-1:0] csrAddr(input csrOffset off);
		return {`SPI_BLOCK_SEL, off};
	endfunction

	// One transfer on host A or B, setup then access until Pready
	task automatic apbXfer(input logic useB, input logic wr, input logic [`SPI_ADDR_W-1:0] addr,
		input logic [`SPI_DATA_W-1:0] wdata, output logic [`SPI_DATA_W-1:0] rdata,
		output logic err);
		int   waitCnt = 0;
		logic ready = 1'b0;
		@(posedge iSysClk);
		if (useB)
		begin
			bPsel    <= 1'b1;
			bPenable <= 1'b0;
			bPwrite  <= wr;
			bPaddr   <= addr;
			bPwdata  <= wdata;
		end
		else
		begin
			aPsel    <= 1'b1;
			aPenable <= 1'b0;
			aPwrite  <= wr;
			aPaddr   <= addr;
			aPwdata  <= wdata;
		end
		@(posedge iSysClk);
		if (useB)
			bPenable <= 1'b1;
		else
			aPenable <= 1'b1;
		// Losing host may wait a whole transfer of the other one
		while (!ready)
		begin
			@(negedge iSysClk);
			ready = useB ? bPready : aPready;
			waitCnt++;
			if (!ready && waitCnt > BUS_TIMEOUT)
				reportTimeout(useB ? "host B Pready" : "host A Pready");
		end
		rdata = useB ? bPrdata : aPrdata;
		err   = useB ? bPslverr : aPslverr;
		@(posedge iSysClk);
		if (useB)
		begin
			bPsel    <= 1'b0;
			bPenable <= 1'b0;
		end
		else
		begin
			aPsel    <= 1'b0;
			aPenable <= 1'b0;
		end
	endtask

	task automatic apbWrite(input logic useB, input logic [`SPI_ADDR_W-1:0] addr,
		input logic [`SPI_DATA_W-1:0] data, output logic err);
		logic [`SPI_DATA_W-1:0] unused;
		apbXfer(useB, 1'b1, addr, data, unused, err);
	endtask

	task automatic apbRead(input logic useB, input logic [`SPI_ADDR_W-1:0] addr,
		output logic [`SPI_DATA_W-1:0] data, output logic err);
		apbXfer(useB, 1'b0, addr, '0, data, err);
	endtask

	// Polls CTRL until busy drops
	task automatic waitIdle(output logic [`SPI_DATA_W-1:0] ctrl);
		int   polls = 0;
		logic err;
		ctrl = 32'h1;
		while (ctrl[0] !== 1'b0)
		begin
			apbRead(1'b0, csrAddr(CSR_CTRL), ctrl, err);
			polls++;
			if (ctrl[0] !== 1'b0 && polls > POLL_LIMIT)
				reportTimeout("CTRL busy to clear");
		end
	endtask

	function automatic logic [7:0] randomByte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic beginTest(input string name);
		curTest    = name;
		testErrors = 0;
	endtask

	task automatic finishTest();
		$display("%-14s %s", curTest, (testErrors == 0) ? "PASS" : "FAIL");
		totalErrors += testErrors;
		if (testErrors == 0)
			passCount++;
		else
			failCount++;
	endtask

	// --------------------
	// Directed tests
	// --------------------
	task automatic testResetValues();
		logic [`SPI_DATA_W-1:0] rd;
		logic                   err;
		beginTest("resetValues");
		checkFlag("csN", 1'b1, csN);
		checkFlag("sclk", 1'b0, sclk);
		checkFlag("aPready", 1'b0, aPready);
		checkFlag("bPready", 1'b0, bPready);
		apbRead(1'b0, csrAddr(CSR_CTRL), rd, err);
		checkData("CTRL", 32'h0, rd);
		apbRead(1'b0, csrAddr(CSR_DIV), rd, err);
		checkData("DIV", 32'h0000FFFF, rd);
		apbRead(1'b0, csrAddr(CSR_CS), rd, err);
		checkData("CS", 32'h1, rd);
		finishTest();
	endtask

	// Written on A, read on B
	task automatic testReadback();
		logic [`SPI_DATA_W-1:0] rd;
		logic                   err;
		logic [7:0]             tx;
		beginTest("readback");
		tx = randomByte();
		apbWrite(1'b0, csrAddr(CSR_DIV), 32'hABCD1234, err);
		apbRead(1'b1, csrAddr(CSR_DIV), rd, err);
		checkData("DIV", 32'h00001234, rd);
		// Upper bits are not stored
		apbWrite(1'b0, csrAddr(CSR_TXDATA), {24'hFFFFFF, tx}, err);
		apbRead(1'b1, csrAddr(CSR_TXDATA), rd, err);
		checkData("TXDATA", {24'h0, tx}, rd);
		apbWrite(1'b0, csrAddr(CSR_CS), 32'h0, err);
		apbRead(1'b1, csrAddr(CSR_CS), rd, err);
		checkData("CS low", 32'h0, rd);
		checkFlag("csN low", 1'b0, csN);
		apbWrite(1'b0, csrAddr(CSR_CS), 32'h1, err);
		apbRead(1'b1, csrAddr(CSR_CS), rd, err);
		checkData("CS high", 32'h1, rd);
		// Hole inside the block
		apbWrite(1'b0, {`SPI_BLOCK_SEL, 8'h10}, 32'hFFFFFFFF, err);
		apbRead(1'b1, {`SPI_BLOCK_SEL, 8'h10}, rd, err);
		checkData("unmapped", 32'h0, rd);
		checkFlag("unmapped Pslverr", 1'b0, err);
		finishTest();
	endtask

	task automatic testTransfer();
		logic [`SPI_DATA_W-1:0] rd;
		logic                   err;
		logic [7:0]             tx;
		beginTest("transfer");
		tx        = randomByte();
		replyByte = randomByte();
		apbWrite(1'b0, csrAddr(CSR_DIV), 32'h1, err);
		apbWrite(1'b0, csrAddr(CSR_TXDATA), {24'h0, tx}, err);
		apbWrite(1'b0, csrAddr(CSR_CS), 32'h0, err);
		apbWrite(1'b0, csrAddr(CSR_CTRL), 32'h1, err);
		waitIdle(rd);
		checkData("CTRL", 32'h2, rd);
		checkByte("slave MOSI", tx, slaveRx);
		apbRead(1'b1, csrAddr(CSR_RXDATA), rd, err);
		checkData("RXDATA", {24'h0, replyByte}, rd);
		apbWrite(1'b0, csrAddr(CSR_CS), 32'h1, err);
		finishTest();
	endtask

	// Both hosts raise Psel on the same edge
	task automatic testContention();
		logic [`SPI_DATA_W-1:0] rd;
		logic                   errA;
		logic                   errB;
		logic [7:0]             tx;
		beginTest("contention");
		tx = randomByte();
		fork
			apbWrite(1'b0, csrAddr(CSR_DIV), 32'h00000042, errA);
			apbWrite(1'b1, csrAddr(CSR_TXDATA), {24'h0, tx}, errB);
		join
		checkFlag("A Pslverr", 1'b0, errA);
		checkFlag("B Pslverr", 1'b0, errB);
		apbRead(1'b1, csrAddr(CSR_DIV), rd, errB);
		checkData("DIV", 32'h00000042, rd);
		apbRead(1'b0, csrAddr(CSR_TXDATA), rd, errA);
		checkData("TXDATA", {24'h0, tx}, rd);
		finishTest();
	endtask

	task automatic testDecodeError();
		logic [`SPI_DATA_W-1:0] rd;
		logic                   err;
		beginTest("decodeError");
		apbWrite(1'b0, csrAddr(CSR_DIV), 32'h00000055, err);
		// Same offset, wrong block
		apbWrite(1'b0, 16'h0404, 32'h00001111, err);
		checkFlag("write Pslverr", 1'b1, err);
		apbRead(1'b1, 16'hFF04, rd, err);
		checkFlag("read Pslverr", 1'b1, err);
		checkData("read Prdata", 32'h0, rd);
		apbRead(1'b1, csrAddr(CSR_DIV), rd, err);
		checkFlag("DIV Pslverr", 1'b0, err);
		checkData("DIV kept", 32'h00000055, rd);
		finishTest();
	endtask

	task automatic testDivider();
		logic [`SPI_DATA_W-1:0] rd;
		logic                   err;
		logic [7:0]             tx;
		beginTest("divider");
		tx        = randomByte();
		replyByte = randomByte();
		apbWrite(1'b0, csrAddr(CSR_DIV), 32'h3, err);
		apbWrite(1'b0, csrAddr(CSR_TXDATA), {24'h0, tx}, err);
		apbWrite(1'b0, csrAddr(CSR_CS), 32'h0, err);
		phaseLen.delete();
		riseCnt   = 0;
		measureOn = 1'b1;
		apbWrite(1'b0, csrAddr(CSR_CTRL), 32'h1, err);
		apbRead(1'b1, csrAddr(CSR_CTRL), rd, err);
		checkFlag("busy", 1'b1, rd[0]);
		// Second start lands mid-frame
		apbWrite(1'b1, csrAddr(CSR_CTRL), 32'h1, err);
		waitIdle(rd);
		checkData("CTRL done", 32'h2, rd);
		apbRead(1'b0, csrAddr(CSR_CTRL), rd, err);
		checkData("CTRL after", 32'h2, rd);
		measureOn = 1'b0;
		// 8 rising and 8 falling edges
		checkData("rising edges", 32'd8, riseCnt);
		checkData("phase count", 32'd15, phaseLen.size());
		foreach (phaseLen[i])
			checkData("phase length", 32'd4, phaseLen[i]);
		checkByte("slave MOSI", tx, slaveRx);
		apbRead(1'b0, csrAddr(CSR_RXDATA), rd, err);
		checkData("RXDATA", {24'h0, replyByte}, rd);
		// Done cleared by any CTRL write
		apbWrite(1'b0, csrAddr(CSR_CTRL), 32'h0, err);
		apbRead(1'b1, csrAddr(CSR_CTRL), rd, err);
		checkData("CTRL cleared", 32'h0, rd);
		apbWrite(1'b0, csrAddr(CSR_CS), 32'h1, err);
		finishTest();
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial
	begin
		rst       = 1'b1;
		aPsel     = 1'b0;
		aPenable  = 1'b0;
		aPwrite   = 1'b0;
		aPaddr    = '0;
		aPwdata   = '0;
		bPsel     = 1'b0;
		bPenable  = 1'b0;
		bPwrite   = 1'b0;
		bPaddr    = '0;
		bPwdata   = '0;
		miso      = 1'b0;
		replyByte = 8'h00;
		curTest   = "reset";
		repeat (2) @(posedge iSysClk);
		rst <= 1'b0;
		@(negedge iSysClk);
		testResetValues();
		testReadback();
		testTransfer();
		testContention();
		testDecodeError();
		testDivider();
		$display("Summary: %0d ok, %0d failing, %0d errors", passCount, failCount, totalErrors);
		if (failCount == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+design
design/spiPkg.sv
design/apbArbiter.sv
design/spiCsr.sv
design/spiShifter.sv
design/spiSubsys.sv
verification/tbSpiSubsys.sv

// File: run.sh
#!/bin/sh
# Build and run the SPI subsystem testbench with Verilator
# Result is taken from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f \
	--top-module tbSpiSubsys --Mdir obj_dir > build.log 2>&1 &&
./obj_dir/VtbSpiSubsys > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log

grep -q "test failed" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "test passed" sim.log || { echo "No result in sim.log"; exit 1; }

exit 0
